// File: apogeo_pkg.sv
`default_nettype none

package apogeo_pkg;

    typedef logic [31:0] data_word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam data_word_t RESET_PC        = 32'h0000_0000;
    localparam data_word_t IRQ_BASE        = 32'h0000_0100;
    localparam data_word_t TIMER_VECTOR_PC = 32'h0000_0080;
    localparam data_word_t MRET_WORD       = 32'h3020_0073;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 / funct7 fields
    localparam logic [2:0] OPC_F3_ADD  = 3'b000;
    localparam logic [2:0] OPC_F3_XOR  = 3'b100;
    localparam logic [2:0] OPC_F3_OR   = 3'b110;
    localparam logic [2:0] OPC_F3_AND  = 3'b111;
    localparam logic [2:0] OPC_F3_SW   = 3'b010;
    localparam logic [2:0] OPC_F3_BEQ  = 3'b000;
    localparam logic [2:0] OPC_F3_BNE  = 3'b001;
    localparam logic [6:0] OPC_F7_BASE = 7'b0000000;
    localparam logic [6:0] OPC_F7_SUB  = 7'b0100000;

    typedef enum logic [3:0] {
        UOP_NOP,
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_LUI,
        UOP_STORE,
        UOP_BEQ,
        UOP_BNE,
        UOP_JAL,
        UOP_MRET
    } uop_t;

    typedef struct packed {
        logic       valid;
        uop_t       uop;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        data_word_t imm;
        logic       use_imm;
        data_word_t pc;
    } issue_pkt_t;

    typedef struct packed {
        logic       valid;
        data_word_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic       valid;
        data_word_t addr;
        data_word_t data;
    } store_req_t;

    typedef struct packed {
        logic       valid;
        data_word_t target;
    } redirect_t;

endpackage : apogeo_pkg

`default_nettype wire

// File: apogeo_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module apogeo_decoder (
    input  apogeo_pkg::data_word_t instr_i,
    input  apogeo_pkg::data_word_t pc_i,
    input  logic                   valid_i,
    output apogeo_pkg::issue_pkt_t pkt_o
);
    import apogeo_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    data_word_t imm_i;
    data_word_t imm_s;
    data_word_t imm_b;
    data_word_t imm_u;
    data_word_t imm_j;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        pkt_o       = '0;
        pkt_o.valid = valid_i;
        pkt_o.pc    = pc_i;
        pkt_o.rs1   = instr_i[19:15];
        pkt_o.rs2   = instr_i[24:20];
        pkt_o.uop   = UOP_NOP;

        case (opcode)
            OPC_OP: begin
                if (funct7 == OPC_F7_BASE) begin
                    case (funct3)
                        OPC_F3_ADD: pkt_o.uop = UOP_ADD;
                        OPC_F3_XOR: pkt_o.uop = UOP_XOR;
                        OPC_F3_OR:  pkt_o.uop = UOP_OR;
                        OPC_F3_AND: pkt_o.uop = UOP_AND;
                        default:    pkt_o.uop = UOP_NOP;
                    endcase
                end else if (funct7 == OPC_F7_SUB && funct3 == OPC_F3_ADD) begin
                    pkt_o.uop = UOP_SUB;
                end
            end
            OPC_OP_IMM: begin
                // only addi
                if (funct3 == OPC_F3_ADD) begin
                    pkt_o.uop     = UOP_ADD;
                    pkt_o.imm     = imm_i;
                    pkt_o.use_imm = 1'b1;
                end
            end
            OPC_LUI: begin
                pkt_o.uop = UOP_LUI;
                pkt_o.imm = imm_u;
            end
            OPC_STORE: begin
                if (funct3 == OPC_F3_SW) begin
                    pkt_o.uop = UOP_STORE;
                    pkt_o.imm = imm_s;
                end
            end
            OPC_BRANCH: begin
                pkt_o.imm = imm_b;
                if (funct3 == OPC_F3_BEQ) begin
                    pkt_o.uop = UOP_BEQ;
                end else if (funct3 == OPC_F3_BNE) begin
                    pkt_o.uop = UOP_BNE;
                end
            end
            OPC_JAL: begin
                pkt_o.uop = UOP_JAL;
                pkt_o.imm = imm_j;
            end
            OPC_SYSTEM: begin
                if (instr_i == MRET_WORD) begin
                    pkt_o.uop = UOP_MRET;
                end
            end
            default: pkt_o.uop = UOP_NOP;
        endcase

        // rd kept only for ops that write back
        case (pkt_o.uop)
            UOP_ADD, UOP_SUB, UOP_AND, UOP_OR, UOP_XOR, UOP_LUI, UOP_JAL: begin
                pkt_o.rd = instr_i[11:7];
            end
            default: pkt_o.rd = '0;
        endcase
    end

endmodule : apogeo_decoder

`default_nettype wire

// File: apogeo_front_end.sv
`timescale 1ns/10ps
`default_nettype none

module apogeo_front_end (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   instr_valid_i,
    input  apogeo_pkg::data_word_t instr_i,
    input  apogeo_pkg::redirect_t  redirect_i,
    output apogeo_pkg::fetch_req_t fetch_o,
    output apogeo_pkg::issue_pkt_t pkt_o
);
    import apogeo_pkg::*;

    typedef enum logic [1:0] {
        FE_RESET,
        FE_WAIT,
        FE_STALE
    } fe_state_t;

    fe_state_t  state_q;
    data_word_t pc_q;
    logic       issue_q;
    logic       accept;

    // response is good only if no redirect overtook its request
    assign accept = instr_valid_i && (state_q == FE_WAIT);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= FE_RESET;
            issue_q <= 1'b0;
            pc_q    <= RESET_PC;
        end else begin
            issue_q <= 1'b0;
            case (state_q)
                FE_RESET: begin
                    state_q <= FE_WAIT;
                    issue_q <= 1'b1;
                end
                FE_WAIT: begin
                    if (instr_valid_i) begin
                        issue_q <= 1'b1;
                    end else if (redirect_i.valid) begin
                        state_q <= FE_STALE;
                    end
                end
                FE_STALE: begin
                    // drop the old response, refetch at the target
                    if (instr_valid_i) begin
                        state_q <= FE_WAIT;
                        issue_q <= 1'b1;
                    end
                end
                default: state_q <= FE_RESET;
            endcase

            if (redirect_i.valid) begin
                pc_q <= redirect_i.target;
            end else if (accept) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    assign fetch_o.valid = issue_q;
    assign fetch_o.addr  = pc_q;

    apogeo_decoder u_decoder (
        .instr_i ( instr_i ),
        .pc_i    ( pc_q    ),
        .valid_i ( accept  ),
        .pkt_o   ( pkt_o   )
    );

endmodule : apogeo_front_end

`default_nettype wire

// File: apogeo_back_end.sv
`timescale 1ns/10ps
`default_nettype none

module apogeo_back_end (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  apogeo_pkg::issue_pkt_t pkt_i,
    input  logic                   pend_ext_i,
    input  logic                   pend_timer_i,
    input  logic [7:0]             vector_i,
    output apogeo_pkg::redirect_t  redirect_o,
    output apogeo_pkg::store_req_t store_o,
    output logic                   take_o,
    output logic                   irq_enable_o
);
    import apogeo_pkg::*;

    data_word_t regfile_q [32];
    data_word_t rs1_val;
    data_word_t rs2_val;
    data_word_t op_b;
    data_word_t result;
    data_word_t link_pc;
    data_word_t branch_pc;
    data_word_t handler_pc;
    data_word_t ret_pc_q;
    logic       in_handler_q;
    logic       exec;
    logic       wb_en;
    logic       taken;

    // x0 reads as zero
    assign rs1_val = (pkt_i.rs1 == '0) ? '0 : regfile_q[pkt_i.rs1];
    assign rs2_val = (pkt_i.rs2 == '0) ? '0 : regfile_q[pkt_i.rs2];
    assign op_b    = pkt_i.use_imm ? pkt_i.imm : rs2_val;

    assign link_pc   = pkt_i.pc + 32'd4;
    assign branch_pc = pkt_i.pc + pkt_i.imm;

    // timer wins over external
    assign handler_pc = pend_timer_i ? TIMER_VECTOR_PC
                                     : IRQ_BASE + {22'b0, vector_i, 2'b00};

    // interrupt replaces the instruction at the boundary
    assign take_o       = pkt_i.valid && !in_handler_q && (pend_ext_i || pend_timer_i);
    assign exec         = pkt_i.valid && !take_o;
    assign irq_enable_o = !in_handler_q;

    always_comb begin
        result = '0;
        wb_en  = 1'b0;
        taken  = 1'b0;
        case (pkt_i.uop)
            UOP_ADD: begin
                result = rs1_val + op_b;
                wb_en  = 1'b1;
            end
            UOP_SUB: begin
                result = rs1_val - op_b;
                wb_en  = 1'b1;
            end
            UOP_AND: begin
                result = rs1_val & op_b;
                wb_en  = 1'b1;
            end
            UOP_OR: begin
                result = rs1_val | op_b;
                wb_en  = 1'b1;
            end
            UOP_XOR: begin
                result = rs1_val ^ op_b;
                wb_en  = 1'b1;
            end
            UOP_LUI: begin
                result = pkt_i.imm;
                wb_en  = 1'b1;
            end
            UOP_JAL: begin
                result = link_pc;
                wb_en  = 1'b1;
                taken  = 1'b1;
            end
            UOP_BEQ: taken = (rs1_val == rs2_val);
            UOP_BNE: taken = (rs1_val != rs2_val);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        redirect_o = '0;
        if (take_o) begin
            redirect_o.valid  = 1'b1;
            redirect_o.target = handler_pc;
        end else if (exec && taken) begin
            redirect_o.valid  = 1'b1;
            redirect_o.target = branch_pc;
        end else if (exec && pkt_i.uop == UOP_MRET) begin
            redirect_o.valid  = 1'b1;
            redirect_o.target = ret_pc_q;
        end
    end

    assign store_o.valid = exec && (pkt_i.uop == UOP_STORE);
    assign store_o.addr  = rs1_val + pkt_i.imm;
    assign store_o.data  = rs2_val;

    always_ff @(posedge clk_i) begin
        if (exec && wb_en && pkt_i.rd != '0) begin
            regfile_q[pkt_i.rd] <= result;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            in_handler_q <= 1'b0;
        end else if (take_o) begin
            in_handler_q <= 1'b1;
        end else if (exec && pkt_i.uop == UOP_MRET) begin
            in_handler_q <= 1'b0;
        end
    end

    // pc of the skipped instruction, resumed by mret
    always_ff @(posedge clk_i) begin
        if (take_o) begin
            ret_pc_q <= pkt_i.pc;
        end
    end

endmodule : apogeo_back_end

`default_nettype wire

// File: apogeo_irq_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module apogeo_irq_ctrl (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       irq_ext_i,
    input  logic       irq_timer_i,
    input  logic [7:0] irq_vector_i,
    input  logic       enable_i,
    input  logic       take_i,
    output logic       pend_ext_o,
    output logic       pend_timer_o,
    output logic [7:0] vector_o
);

    logic ext_masked;
    logic timer_masked;
    logic ext_prev_q;
    logic timer_prev_q;
    logic ext_edge;
    logic timer_edge;
    logic pend_ext_q;
    logic pend_timer_q;
    logic [7:0] vector_q;

    assign ext_masked   = irq_ext_i & enable_i;
    assign timer_masked = irq_timer_i & enable_i;

    assign ext_edge   = ext_masked & ~ext_prev_q;
    assign timer_edge = timer_masked & ~timer_prev_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ext_prev_q   <= 1'b0;
            timer_prev_q <= 1'b0;
            pend_ext_q   <= 1'b0;
            pend_timer_q <= 1'b0;
        end else begin
            ext_prev_q   <= ext_masked;
            timer_prev_q <= timer_masked;

            // take retires the timer first, same priority as the back end
            if (timer_edge) begin
                pend_timer_q <= 1'b1;
            end else if (take_i && pend_timer_q) begin
                pend_timer_q <= 1'b0;
            end

            if (ext_edge) begin
                pend_ext_q <= 1'b1;
            end else if (take_i && !pend_timer_q) begin
                pend_ext_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ext_edge) begin
            vector_q <= irq_vector_i;
        end
    end

    assign pend_ext_o   = pend_ext_q;
    assign pend_timer_o = pend_timer_q;
    assign vector_o     = vector_q;

endmodule : apogeo_irq_ctrl

`default_nettype wire

// File: rv32apogeo.sv
`timescale 1ns/10ps
`default_nettype none

module rv32apogeo (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    output logic                   fetch_req_o,
    output apogeo_pkg::data_word_t fetch_addr_o,
    input  logic                   instr_valid_i,
    input  apogeo_pkg::data_word_t instr_i,
    output logic                   store_req_o,
    output apogeo_pkg::data_word_t store_addr_o,
    output apogeo_pkg::data_word_t store_data_o,
    input  logic                   irq_ext_i,
    input  logic                   irq_timer_i,
    input  logic [7:0]             irq_vector_i,
    output logic                   irq_ack_o
);
    import apogeo_pkg::*;

    fetch_req_t fe_fetch;
    issue_pkt_t fe_pkt;
    issue_pkt_t pipe_pkt_q;
    issue_pkt_t be_pkt;
    logic       pipe_valid_q;
    redirect_t  redirect;
    store_req_t be_store;
    logic       take;
    logic       irq_enable;
    logic       pend_ext;
    logic       pend_timer;
    logic [7:0] pend_vector;

    apogeo_front_end u_front_end (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .instr_valid_i ( instr_valid_i ),
        .instr_i       ( instr_i       ),
        .redirect_i    ( redirect      ),
        .fetch_o       ( fe_fetch      ),
        .pkt_o         ( fe_pkt        )
    );

    // pipeline register, flushed by any redirect
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pipe_valid_q <= 1'b0;
        end else if (redirect.valid) begin
            pipe_valid_q <= 1'b0;
        end else begin
            pipe_valid_q <= fe_pkt.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        pipe_pkt_q <= fe_pkt;
    end

    always_comb begin
        be_pkt       = pipe_pkt_q;
        be_pkt.valid = pipe_valid_q;
    end

    apogeo_back_end u_back_end (
        .clk_i        ( clk_i       ),
        .rst_n_i      ( rst_n_i     ),
        .pkt_i        ( be_pkt      ),
        .pend_ext_i   ( pend_ext    ),
        .pend_timer_i ( pend_timer  ),
        .vector_i     ( pend_vector ),
        .redirect_o   ( redirect    ),
        .store_o      ( be_store    ),
        .take_o       ( take        ),
        .irq_enable_o ( irq_enable  )
    );

    apogeo_irq_ctrl u_irq_ctrl (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .irq_ext_i    ( irq_ext_i    ),
        .irq_timer_i  ( irq_timer_i  ),
        .irq_vector_i ( irq_vector_i ),
        .enable_i     ( irq_enable   ),
        .take_i       ( take         ),
        .pend_ext_o   ( pend_ext     ),
        .pend_timer_o ( pend_timer   ),
        .vector_o     ( pend_vector  )
    );

    // outward channel flops
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            fetch_req_o <= 1'b0;
            store_req_o <= 1'b0;
            irq_ack_o   <= 1'b0;
        end else begin
            fetch_req_o <= fe_fetch.valid;
            store_req_o <= be_store.valid;
            irq_ack_o   <= take;
        end
    end

    always_ff @(posedge clk_i) begin
        fetch_addr_o <= fe_fetch.addr;
        store_addr_o <= be_store.addr;
        store_data_o <= be_store.data;
    end

endmodule : rv32apogeo

`default_nettype wire

// File: rv32apogeo_sva.sv
`timescale 1ns/10ps
`default_nettype none

module rv32apogeo_sva (
    input logic clk_i,
    input logic rst_n_i,
    input logic fetch_req_i,
    input logic instr_valid_i,
    input logic store_req_i,
    input logic irq_ack_i
);

    logic outstanding_q;

    // one fetch in flight until its response
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            outstanding_q <= 1'b0;
        end else if (fetch_req_i) begin
            outstanding_q <= 1'b1;
        end else if (instr_valid_i) begin
            outstanding_q <= 1'b0;
        end
    end

    a_single_fetch: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_req_i |-> !outstanding_q)
        else $error("fetch issued while another is outstanding");

    a_reset_strobes: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !fetch_req_i && !store_req_i && !irq_ack_i)
        else $error("strobe high after reset");

    a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_ack_i |=> !irq_ack_i)
        else $error("irq_ack_o longer than one cycle");

endmodule : rv32apogeo_sva

`default_nettype wire

// File: tb_rv32apogeo.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv32apogeo;

    localparam int PROG_WORDS = 44;
    localparam int TIMEOUT    = 80 * PROG_WORDS;

    logic        clk_i;
    logic        rst_n_i;
    logic        fetch_req_o;
    logic [31:0] fetch_addr_o;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        store_req_o;
    logic [31:0] store_addr_o;
    logic [31:0] store_data_o;
    logic        irq_ext_i;
    logic        irq_timer_i;
    logic [7:0]  irq_vector_i;
    logic        irq_ack_o;

    logic [31:0] mem [256];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_tags [$];
    int          main_seen;
    int          handler_seen;
    int          ack_count;
    int          cycles;
    integer      seed;
    logic        pending;
    logic [31:0] pend_addr;
    int          wait_cnt;

    rv32apogeo dut (.*);

    bind rv32apogeo rv32apogeo_sva u_sva (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .fetch_req_i   ( fetch_req_o   ),
        .instr_valid_i ( instr_valid_i ),
        .store_req_i   ( store_req_o   ),
        .irq_ack_i     ( irq_ack_o     )
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // handler stores 0x2000 plus its tag at 0x2000 and returns with mret
    task automatic put_handler(input int base, input logic [11:0] tag);
        mem[base]     = {20'h00002, 5'd31, 7'b0110111};
        mem[base + 1] = itype(tag, 31, 31);
        mem[base + 2] = stype(-tag, 31, 31);
        mem[base + 3] = 32'h3020_0073;
        exp_tags.push_back(32'h2000 + tag);
    endtask

    task automatic load_program();
        // custom-0 fill retires as nop and carries the word address
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[24:0], 7'b0001011};
        end
        mem[0]  = itype(12'd5, 0, 1);
        mem[1]  = itype(12'hffd, 0, 2);
        mem[2]  = rtype(7'h00, 2, 1, 3'b000, 3);
        mem[3]  = rtype(7'h20, 2, 1, 3'b000, 4);
        mem[4]  = rtype(7'h00, 2, 1, 3'b111, 5);
        mem[5]  = rtype(7'h00, 2, 1, 3'b110, 6);
        mem[6]  = rtype(7'h00, 2, 1, 3'b100, 7);
        mem[7]  = {20'habcde, 5'd8, 7'b0110111};
        mem[8]  = stype(12'd0, 3, 0);
        mem[9]  = stype(12'd4, 4, 0);
        mem[10] = stype(12'd8, 5, 0);
        mem[11] = stype(12'd12, 6, 0);
        mem[12] = stype(12'd16, 7, 0);
        mem[13] = stype(12'd20, 8, 0);
        mem[14] = btype(13'd8, 2, 1, 3'b000);
        mem[15] = btype(13'd8, 2, 1, 3'b001);
        mem[16] = stype(12'h100, 1, 0);
        mem[17] = rtype(7'h00, 1, 8, 3'b000, 9);
        mem[18] = btype(13'd8, 1, 1, 3'b000);
        mem[19] = stype(12'h104, 1, 0);
        mem[20] = jtype(21'd8, 10);
        mem[21] = stype(12'h108, 1, 0);
        mem[22] = stype(12'd24, 10, 0);
        mem[23] = stype(12'd28, 9, 0);
        mem[24] = btype(13'd8, 1, 1, 3'b001);
        mem[25] = stype(12'd32, 2, 0);
        mem[26] = itype(12'd0, 0, 13);
        mem[27] = itype(12'd12, 0, 14);
        // counted loop
        mem[28] = itype(12'd1, 13, 13);
        mem[29] = stype(12'd40, 13, 0);
        mem[30] = btype(13'h1ff8, 14, 13, 3'b001);
        mem[31] = jtype(21'd0, 0);
        // serviced as ext vector 0 then timer then ext vector 8
        put_handler(64, 12'h011);
        put_handler(32, 12'h033);
        put_handler(72, 12'h022);
    endtask

    // architectural model of the main program without interrupts
    function automatic void build_expected();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] nxt;
        logic [31:0] val;
        logic        wr;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc = '0;
        for (int step = 0; step < 2000; step++) begin
            w   = mem[pc[9:2]];
            a   = regs[w[19:15]];
            b   = regs[w[24:20]];
            nxt = pc + 4;
            wr  = 1'b0;
            val = '0;
            case (w[6:0])
                7'b0110011: begin
                    wr = 1'b1;
                    if (w[31:25] == 7'h20 && w[14:12] == 3'b000) val = a - b;
                    else if (w[14:12] == 3'b000) val = a + b;
                    else if (w[14:12] == 3'b100) val = a ^ b;
                    else if (w[14:12] == 3'b110) val = a | b;
                    else if (w[14:12] == 3'b111) val = a & b;
                    else wr = 1'b0;
                end
                7'b0010011: begin
                    wr  = (w[14:12] == 3'b000);
                    val = a + {{20{w[31]}}, w[31:20]};
                end
                7'b0110111: begin
                    wr  = 1'b1;
                    val = {w[31:12], 12'b0};
                end
                7'b0100011: begin
                    exp_addr.push_back(a + {{20{w[31]}}, w[31:25], w[11:7]});
                    exp_data.push_back(b);
                end
                7'b1100011: begin
                    if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b))
                        nxt = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
                7'b1101111: begin
                    wr  = 1'b1;
                    val = pc + 4;
                    nxt = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && w[11:7] != 0) regs[w[11:7]] = val;
            // jump to self ends the program
            if (nxt == pc) return;
            pc = nxt;
        end
    endfunction

    // fetch responder
    always @(negedge clk_i) begin
        instr_valid_i = 1'b0;
        if (rst_n_i && fetch_req_o) begin
            pending   = 1'b1;
            pend_addr = fetch_addr_o;
            wait_cnt  = {$random(seed)} % 4 + 1;
        end
        if (pending) begin
            if (wait_cnt == 0) begin
                instr_valid_i = 1'b1;
                instr_i       = mem[pend_addr[9:2]];
                pending       = 1'b0;
            end else begin
                wait_cnt--;
            end
        end
    end

    // store checker
    always @(negedge clk_i) begin
        if (rst_n_i && irq_ack_o) ack_count++;
        if (rst_n_i && store_req_o) begin
            if (store_addr_o == 32'h2000) begin
                assert (handler_seen < exp_tags.size())
                    else fail_run("handler store with no interrupt left to service");
                assert (store_data_o == exp_tags[handler_seen])
                    else fail_run($sformatf("mismatch store_data_o: got %h expected %h",
                                            store_data_o, exp_tags[handler_seen]));
                handler_seen++;
            end else begin
                assert (main_seen < exp_addr.size())
                    else fail_run("main program stored more often than expected");
                assert (store_addr_o == exp_addr[main_seen])
                    else fail_run($sformatf("mismatch store_addr_o: got %h expected %h",
                                            store_addr_o, exp_addr[main_seen]));
                assert (store_data_o == exp_data[main_seen])
                    else fail_run($sformatf("mismatch store_data_o: got %h expected %h",
                                            store_data_o, exp_data[main_seen]));
                main_seen++;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        assert (cycles <= TIMEOUT)
            else fail_run("timeout: program did not finish in time");
    end

    initial begin
        seed          = 32'he1ca;
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        irq_ext_i     = 1'b0;
        irq_timer_i   = 1'b0;
        irq_vector_i  = 8'd0;
        pending       = 1'b0;
        pend_addr     = '0;
        wait_cnt      = 0;
        main_seen     = 0;
        handler_seen  = 0;
        ack_count     = 0;
        cycles        = 0;
        load_program();
        build_expected();
        repeat (4) @(negedge clk_i);
        rst_n_i = 1'b1;

        // external edge with vector 0
        while (main_seen < 4) @(negedge clk_i);
        irq_ext_i = 1'b1;
        while (!irq_ack_o) @(negedge clk_i);
        irq_ext_i = 1'b0;
        while (handler_seen < 1) @(negedge clk_i);

        // timer then an external edge while its handler runs
        while (main_seen < 12) @(negedge clk_i);
        irq_timer_i = 1'b1;
        while (!irq_ack_o) @(negedge clk_i);
        irq_timer_i  = 1'b0;
        irq_vector_i = 8'd8;
        irq_ext_i    = 1'b1;
        @(negedge clk_i);
        while (!irq_ack_o) @(negedge clk_i);
        irq_ext_i = 1'b0;

        while (main_seen < exp_addr.size() || handler_seen < 3) @(negedge clk_i);
        repeat (40) @(negedge clk_i);
        assert (ack_count == 3)
            else fail_run($sformatf("mismatch irq_ack_o count: got %h expected %h",
                                    ack_count, 3));
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule : tb_rv32apogeo

`default_nettype wire

// File: rv32apogeo.f
apogeo_pkg.sv
apogeo_decoder.sv
apogeo_front_end.sv
apogeo_back_end.sv
apogeo_irq_ctrl.sv
rv32apogeo.sv
rv32apogeo_sva.sv
tb_rv32apogeo.sv

// File: Bender.yml
package:
  name: rv32apogeo

sources:
  - apogeo_pkg.sv
  - apogeo_decoder.sv
  - apogeo_front_end.sv
  - apogeo_back_end.sv
  - apogeo_irq_ctrl.sv
  - rv32apogeo.sv
  - target: test
    files:
      - rv32apogeo_sva.sv
      - tb_rv32apogeo.sv
